// ==== verilog/intra4_pkg.sv ====
package intra4_pkg;

    // ----------------------------------------------------------------------
    // Pixel and block types
    // ----------------------------------------------------------------------

    typedef logic [7:0] pix_t;

    // Index 0 is the leftmost pixel of the row
    typedef pix_t [3:0] row4_t;

    // Row 0 is the top row
    typedef struct packed {
        row4_t [3:0] row;
    } blk4_t;

    // Neighbors of the 4x4 block, top[0] leftmost, left[0] topmost
    typedef struct packed {
        pix_t       top_left;
        pix_t [3:0] top;
        pix_t       top_right;
        pix_t [3:0] left;
    } nbr_t;

    typedef logic [15:0] lambda_t;

    // 16 * 255^2 still fits in 21 bits
    typedef logic [20:0] sse_t;
    typedef logic [31:0] score_t;

    // ----------------------------------------------------------------------
    // Modes and their header costs
    // ----------------------------------------------------------------------

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } i4_mode_e;

    localparam int NUM_MODES = 4;

    localparam logic [11:0] MODE_COST [NUM_MODES] = '{
        12'd40,
        12'd1151,
        12'd1723,
        12'd1874
    };

    // One prediction per mode, indexed by i4_mode_e
    typedef struct packed {
        blk4_t [NUM_MODES-1:0] blk;
    } pred_set_t;

    typedef struct packed {
        blk4_t     src;
        lambda_t   lambda;
        pred_set_t preds;
    } job_t;

    typedef struct packed {
        sse_t [NUM_MODES-1:0] sse;
    } sse_set_t;

endpackage

// ==== verilog/intra4_predict.sv ====
`timescale 1ns/1ns

module intra4_predict (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  intra4_pkg::lambda_t lambda_i,
    input  intra4_pkg::blk4_t   src_i,
    input  intra4_pkg::nbr_t    nbr_i,
    input  logic                done_i,
    output logic                busy_o,
    output intra4_pkg::job_t    job_o,
    output logic                job_valid_o
);
    import intra4_pkg::*;

    logic      busy_q;
    logic      cap_q;
    logic      job_valid_q;
    logic      accept;
    nbr_t      nbr_q;
    blk4_t     src_q;
    lambda_t   lambda_q;
    pred_set_t pred_d;
    pred_set_t pred_q;

    // Extended top row and left column for the 3-tap filters
    pix_t [5:0]  te;
    pix_t [5:0]  le;
    logic [10:0] dc_sum;

    function automatic pix_t avg3(pix_t a, pix_t b, pix_t c);
        logic [9:0] s;
        s = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c} + 10'd2;
        return s[9:2];
    endfunction

    function automatic pix_t tm_pix(pix_t l, pix_t t, pix_t tl);
        logic signed [10:0] v;
        v = $signed({3'b000, l}) + $signed({3'b000, t}) - $signed({3'b000, tl});
        if (v < 0)
            return 8'd0;
        if (v > 255)
            return 8'd255;
        return v[7:0];
    endfunction

    assign accept = start_i && !busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            cap_q       <= 1'b0;
            job_valid_q <= 1'b0;
        end else begin
            cap_q       <= accept;
            job_valid_q <= cap_q;
            if (accept)
                busy_q <= 1'b1;
            else if (done_i)
                busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            nbr_q    <= nbr_i;
            src_q    <= src_i;
            lambda_q <= lambda_i;
        end
        if (cap_q)
            pred_q <= pred_d;
    end

    // ----------------------------------------------------------------------
    // DC, TM, VE and HE predictors
    // ----------------------------------------------------------------------

    always_comb begin
        te = {nbr_q.top_right, nbr_q.top, nbr_q.top_left};
        le = {nbr_q.left[3], nbr_q.left, nbr_q.top_left};
        dc_sum = 11'd4;
        for (int i = 0; i < 4; i++) begin
            dc_sum = dc_sum + nbr_q.top[i] + nbr_q.left[i];
        end
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                pred_d.blk[MODE_DC].row[y][x] = dc_sum[10:3];
                pred_d.blk[MODE_TM].row[y][x] = tm_pix(nbr_q.left[y], nbr_q.top[x],
                                                       nbr_q.top_left);
                pred_d.blk[MODE_VE].row[y][x] = avg3(te[x], te[x+1], te[x+2]);
                pred_d.blk[MODE_HE].row[y][x] = avg3(le[y], le[y+1], le[y+2]);
            end
        end
    end

    assign busy_o       = busy_q;
    assign job_valid_o  = job_valid_q;
    assign job_o.src    = src_q;
    assign job_o.lambda = lambda_q;
    assign job_o.preds  = pred_q;

endmodule

// ==== verilog/intra4_sse.sv ====
`timescale 1ns/1ns

module intra4_sse (
    input  logic                  clk,
    input  logic                  rst_n,
    input  intra4_pkg::job_t      job_i,
    input  logic                  job_valid_i,
    output intra4_pkg::sse_set_t  sse_o,
    output intra4_pkg::pred_set_t preds_o,
    output intra4_pkg::lambda_t   lambda_o,
    output logic                  sse_valid_o
);
    import intra4_pkg::*;

    typedef enum logic {
        SSE_IDLE,
        SSE_ACC
    } sse_state_e;

    sse_state_e  state_q;
    logic [1:0]  row_q;
    logic        sse_valid_q;
    sse_set_t    acc_q;
    logic [17:0] row_sse [NUM_MODES];

    function automatic logic [15:0] sq_diff(pix_t a, pix_t b);
        logic [15:0] d;
        d = (a > b) ? 16'(a - b) : 16'(b - a);
        return d * d;
    endfunction

    // Squared error of the current row against every prediction
    always_comb begin
        for (int m = 0; m < NUM_MODES; m++) begin
            row_sse[m] = '0;
            for (int x = 0; x < 4; x++) begin
                row_sse[m] = row_sse[m] + sq_diff(job_i.src.row[row_q][x],
                                                  job_i.preds.blk[m].row[row_q][x]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= SSE_IDLE;
            row_q       <= 2'd0;
            sse_valid_q <= 1'b0;
        end else begin
            sse_valid_q <= 1'b0;
            case (state_q)
                SSE_IDLE: begin
                    if (job_valid_i) begin
                        row_q   <= row_q + 2'd1;
                        state_q <= SSE_ACC;
                    end
                end
                SSE_ACC: begin
                    row_q <= row_q + 2'd1;
                    if (row_q == 2'd3) begin
                        sse_valid_q <= 1'b1;
                        state_q     <= SSE_IDLE;
                    end
                end
                default: state_q <= SSE_IDLE;
            endcase
        end
    end

    // First row overwrites, later rows add
    always_ff @(posedge clk) begin
        for (int m = 0; m < NUM_MODES; m++) begin
            if (state_q == SSE_IDLE && job_valid_i)
                acc_q.sse[m] <= sse_t'(row_sse[m]);
            else if (state_q == SSE_ACC)
                acc_q.sse[m] <= acc_q.sse[m] + sse_t'(row_sse[m]);
        end
    end

    assign sse_o       = acc_q;
    assign sse_valid_o = sse_valid_q;
    assign preds_o     = job_i.preds;
    assign lambda_o    = job_i.lambda;

endmodule

// ==== verilog/intra4_mode_select.sv ====
`timescale 1ns/1ns

module intra4_mode_select (
    input  logic                  clk,
    input  logic                  rst_n,
    input  intra4_pkg::sse_set_t  sse_i,
    input  intra4_pkg::pred_set_t preds_i,
    input  intra4_pkg::lambda_t   lambda_i,
    input  logic                  sse_valid_i,
    output intra4_pkg::i4_mode_e  mode_o,
    output intra4_pkg::blk4_t     pred_o,
    output intra4_pkg::score_t    score_o,
    output logic                  done_o
);
    import intra4_pkg::*;

    score_t   score [NUM_MODES];
    score_t   best_score;
    i4_mode_e best;

    // ----------------------------------------------------------------------
    // Rate-distortion score and minimum search
    // ----------------------------------------------------------------------

    always_comb begin
        for (int m = 0; m < NUM_MODES; m++) begin
            score[m] = (score_t'(sse_i.sse[m]) << 8)
                     + score_t'(MODE_COST[m]) * score_t'(lambda_i);
        end
        best       = MODE_DC;
        best_score = score[0];
        // Strict compare keeps the lower mode on a tie
        for (int m = 1; m < NUM_MODES; m++) begin
            if (score[m] < best_score) begin
                best       = i4_mode_e'(m);
                best_score = score[m];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_o  <= MODE_DC;
            pred_o  <= '0;
            score_o <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= sse_valid_i;
            if (sse_valid_i) begin
                mode_o  <= best;
                pred_o  <= preds_i.blk[best];
                score_o <= best_score;
            end
        end
    end

endmodule

// ==== verilog/intra4_pick.sv ====
`timescale 1ns/1ns

module intra4_pick (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  intra4_pkg::lambda_t  lambda_i,
    input  intra4_pkg::blk4_t    src_i,
    input  intra4_pkg::nbr_t     nbr_i,
    output logic                 busy_o,
    output logic                 done_o,
    output intra4_pkg::i4_mode_e mode_o,
    output intra4_pkg::blk4_t    pred_o,
    output intra4_pkg::score_t   score_o
);
    import intra4_pkg::*;

    job_t      job;
    logic      job_valid;
    sse_set_t  sse;
    pred_set_t preds;
    lambda_t   lambda;
    logic      sse_valid;

    intra4_predict i_intra4_predict (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .lambda_i    (lambda_i),
        .src_i       (src_i),
        .nbr_i       (nbr_i),
        .done_i      (done_o),
        .busy_o      (busy_o),
        .job_o       (job),
        .job_valid_o (job_valid)
    );

    intra4_sse i_intra4_sse (
        .clk         (clk),
        .rst_n       (rst_n),
        .job_i       (job),
        .job_valid_i (job_valid),
        .sse_o       (sse),
        .preds_o     (preds),
        .lambda_o    (lambda),
        .sse_valid_o (sse_valid)
    );

    intra4_mode_select i_intra4_mode_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .sse_i       (sse),
        .preds_i     (preds),
        .lambda_i    (lambda),
        .sse_valid_i (sse_valid),
        .mode_o      (mode_o),
        .pred_o      (pred_o),
        .score_o     (score_o),
        .done_o      (done_o)
    );

endmodule

// ==== sim/intra4_pick_assert.sv ====
`timescale 1ns/1ns

module intra4_pick_assert (
    input logic clk,
    input logic rst_n,
    input logic busy_o,
    input logic done_o
);

    property done_one_cycle;
        @(posedge clk) disable iff (!rst_n) done_o |=> !done_o;
    endproperty

    property busy_drops_after_done;
        @(posedge clk) disable iff (!rst_n) done_o |=> !busy_o;
    endproperty

    property done_only_when_busy;
        @(posedge clk) disable iff (!rst_n) done_o |-> busy_o;
    endproperty

    a_done_one_cycle: assert property (done_one_cycle)
        else $error("done_o high two cycles in a row");
    a_busy_drops: assert property (busy_drops_after_done)
        else $error("busy_o still high the cycle after done_o");
    a_done_busy: assert property (done_only_when_busy)
        else $error("done_o high while busy_o is low");

endmodule

bind intra4_pick intra4_pick_assert i_intra4_pick_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .busy_o (busy_o),
    .done_o (done_o)
);

// ==== sim/intra4_pick_tb.sv ====
`timescale 1ns/1ns

module intra4_pick_tb;
    import intra4_pkg::*;

    typedef struct packed {
        i4_mode_e mode;
        blk4_t    blk;
        score_t   score;
    } result_t;

    localparam int RUN_JOBS    = 300;
    localparam int TIMEOUT_CYC = RUN_JOBS * 10 + 50;
    localparam int RAND_JOBS   = 280;

    // Header cost per mode in DC TM VE HE order
    localparam int COST_TAB [4] = '{40, 1151, 1723, 1874};

    logic    clk;
    logic    rst_n;
    logic    start_i;
    lambda_t lambda_i;
    blk4_t   src_i;
    nbr_t    nbr_i;
    logic    busy_o;
    logic    done_o;
    i4_mode_e mode_o;
    blk4_t   pred_o;
    score_t  score_o;

    integer  seed;
    int      cycles;
    int      lat;
    result_t exp_q [$];

    intra4_pick i_intra4_pick (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start_i),
        .lambda_i (lambda_i),
        .src_i    (src_i),
        .nbr_i    (nbr_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .mode_o   (mode_o),
        .pred_o   (pred_o),
        .score_o  (score_o)
    );

    always #50 clk = ~clk;

    task automatic report_failure(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [127:0] exp, logic [127:0] act);
        if (exp !== act)
            report_failure($sformatf("ERR %s exp=%h act=%h", name, exp, act));
    endtask

    // ----------------------------------------------------------------------
    // Reference model of prediction and mode choice
    // ----------------------------------------------------------------------

    function automatic result_t ref_pick(blk4_t s, nbr_t n, lambda_t l);
        int      tt [6];
        int      ll [6];
        int      pred [4][4][4];
        int      dc;
        int      v;
        int      bm;
        longint  sse;
        longint  sc;
        longint  best_sc;
        result_t r;
        tt[0] = n.top_left;
        tt[5] = n.top_right;
        ll[0] = n.top_left;
        ll[5] = n.left[3];
        dc = 4;
        for (int i = 0; i < 4; i++) begin
            tt[i+1] = n.top[i];
            ll[i+1] = n.left[i];
            dc = dc + n.top[i] + n.left[i];
        end
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                v = ll[y+1] + tt[x+1] - tt[0];
                pred[0][y][x] = dc >> 3;
                pred[1][y][x] = (v < 0) ? 0 : ((v > 255) ? 255 : v);
                pred[2][y][x] = (tt[x] + 2 * tt[x+1] + tt[x+2] + 2) >> 2;
                pred[3][y][x] = (ll[y] + 2 * ll[y+1] + ll[y+2] + 2) >> 2;
            end
        end
        best_sc = -1;
        bm = 0;
        for (int m = 0; m < 4; m++) begin
            sse = 0;
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    v = int'(s.row[y][x]) - pred[m][y][x];
                    sse = sse + v * v;
                end
            end
            sc = (sse << 8) + longint'(COST_TAB[m]) * longint'(l);
            if (best_sc < 0 || sc < best_sc) begin
                best_sc = sc;
                bm = m;
            end
        end
        r.mode = i4_mode_e'(bm);
        r.score = score_t'(best_sc);
        for (int y = 0; y < 4; y++)
            for (int x = 0; x < 4; x++)
                r.blk.row[y][x] = pix_t'(pred[bm][y][x]);
        return r;
    endfunction

    task automatic rand_job(output blk4_t s, output nbr_t n, output lambda_t l);
        logic [31:0] rnd;
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            s.row[i] = rnd;
        end
        rnd = $random(seed);
        n.top = rnd;
        rnd = $random(seed);
        n.left = rnd;
        rnd = $random(seed);
        n.top_left = rnd[7:0];
        n.top_right = rnd[15:8];
        l = rnd[31:16];
        // Small weights let the non-DC modes win now and then
        if (rnd[0])
            l = l & 16'h003f;
    endtask

    task automatic start_job(blk4_t s, nbr_t n, lambda_t l);
        @(negedge clk);
        while (busy_o)
            @(negedge clk);
        @(posedge clk);
        start_i  <= 1'b1;
        src_i    <= s;
        nbr_i    <= n;
        lambda_i <= l;
        exp_q.push_back(ref_pick(s, n, l));
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYC)
            report_failure($sformatf("Timeout: run did not end within %0d cycles", TIMEOUT_CYC));
    end

    // ----------------------------------------------------------------------
    // Compare process, latency tracking and result checks
    // ----------------------------------------------------------------------

    always @(negedge clk) begin
        result_t e;
        if (rst_n) begin
            if (lat > -2)
                lat = lat + 1;
            if (lat == 7) begin
                check_val("busy_o", 0, busy_o);
                check_val("done_o", 0, done_o);
                lat = -2;
            end
            if (start_i && !busy_o)
                lat = -1;
            if (done_o) begin
                check_val("done_latency", 6, lat);
                check_val("busy_o", 1, busy_o);
                if (exp_q.size() == 0)
                    report_failure("done_o pulsed with no job in flight");
                e = exp_q.pop_front();
                check_val("mode_o", e.mode, mode_o);
                check_val("pred_o", e.blk, pred_o);
                check_val("score_o", e.score, score_o);
            end
        end
    end

    initial begin
        blk4_t   s;
        nbr_t    n;
        lambda_t l;
        result_t r;
        seed      = 57539;
        cycles    = 0;
        lat       = -2;
        clk       = 1'b0;
        rst_n     = 1'b0;
        start_i   = 1'b0;
        lambda_i  = '0;
        src_i     = '0;
        nbr_i     = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        repeat (3) begin
            @(negedge clk);
            check_val("busy_o", 0, busy_o);
            check_val("done_o", 0, done_o);
        end

        // Flat block gives every mode zero error
        s = {16{8'd100}};
        n = {10{8'd100}};
        r = ref_pick(s, n, 16'd0);
        check_val("ref_tie_mode", MODE_DC, r.mode);
        check_val("ref_tie_score", 0, r.score);
        start_job(s, n, 16'd0);
        r = ref_pick(s, n, 16'd1);
        check_val("ref_tie_mode", MODE_DC, r.mode);
        check_val("ref_tie_score", 40, r.score);
        start_job(s, n, 16'd1);

        // TM clipped to 0
        n = '0;
        n.top_left = 8'd255;
        for (int i = 0; i < 4; i++)
            n.left[i] = 8'd64 + 8'($random(seed) & 63);
        s = '0;
        r = ref_pick(s, n, 16'd0);
        check_val("ref_clip_lo_mode", MODE_TM, r.mode);
        check_val("ref_clip_lo_blk", s, r.blk);
        start_job(s, n, 16'd0);

        // TM clipped to 255
        n.top_left = 8'd0;
        n.top = {4{8'hff}};
        n.top_right = 8'hff;
        s = {16{8'hff}};
        r = ref_pick(s, n, 16'd0);
        check_val("ref_clip_hi_mode", MODE_TM, r.mode);
        check_val("ref_clip_hi_blk", s, r.blk);
        start_job(s, n, 16'd0);

        // Starts during a job carry other data and must be dropped
        rand_job(s, n, l);
        start_job(s, n, l);
        repeat (3) begin
            rand_job(s, n, l);
            @(posedge clk);
            start_i  <= 1'b1;
            src_i    <= s;
            nbr_i    <= n;
            lambda_i <= l;
        end
        @(posedge clk);
        start_i <= 1'b0;

        for (int j = 0; j < RAND_JOBS; j++) begin
            rand_job(s, n, l);
            start_job(s, n, l);
        end

        // Drain until the last job has also passed its busy_o check
        @(negedge clk);
        while (busy_o || exp_q.size() != 0 || lat != -2)
            @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== intra4_pick.f ====
verilog/intra4_pkg.sv
verilog/intra4_predict.sv
verilog/intra4_sse.sv
verilog/intra4_mode_select.sv
verilog/intra4_pick.sv
sim/intra4_pick_assert.sv
sim/intra4_pick_tb.sv

// ==== Bender.yml ====
package:
  name: intra4_pick

sources:
  - files:
      - verilog/intra4_pkg.sv
      - verilog/intra4_predict.sv
      - verilog/intra4_sse.sv
      - verilog/intra4_mode_select.sv
      - verilog/intra4_pick.sv
  - target: simulation
    files:
      - sim/intra4_pick_assert.sv
      - sim/intra4_pick_tb.sv
